/* rtl/mvu_pkg.sv */
// MVU shared definitions: element widths, accumulator width and saturation bounds.
package mvu_pkg;

   // Activation element width.
   // Signed, two's complement.
   localparam int TSRCI = 4;

   // Weight element width.
   localparam int TW = 4;

   // Output element width after saturation.
   localparam int TDSTI = 16;

   // Accumulator width.
   // Holds SF * SIMD full-scale products without wrapping.
   localparam int TACC = 24;

   // Width of one signed product.
   localparam int TPROD = TSRCI + TW;

   // Largest positive output value.
   localparam logic signed [TACC-1:0] ACC_MAX = TACC'((2 ** (TDSTI - 1)) - 1);

   // Most negative output value.
   // Bitwise inverse of the max is -2^(TDSTI-1).
   localparam logic signed [TACC-1:0] ACC_MIN = ~ACC_MAX;

endpackage

/* rtl/mvu_beat_if.sv */
// MVU beat interface: one decoded input beat from fold control to the PE array.
`timescale 1ns/10ps

interface mvu_beat_if #(
   parameter int SIMD = 4
);
   import mvu_pkg::*;

   // Beat is valid this cycle.
   logic en;
   // Start of fold, load instead of add.
   logic first;
   // Final beat of the fold.
   logic last;
   // Registered activation slice.
   // Element 0 in the low bits.
   logic [SIMD*TSRCI-1:0] act;

   // Fold control side.
   modport ctrl (
      output en,
      output first,
      output last,
      output act
   );

   // PE side.
   modport pe (
      input en,
      input first,
      input last,
      input act
   );

endinterface

/* rtl/mvu_fold_ctrl.sv */
// MVU fold control: counts valid beats over the fold and registers the beat controls.
`timescale 1ns/10ps

module mvu_fold_ctrl #(
   parameter int SIMD = 4,
   parameter int PE   = 4,
   parameter int SF   = 8
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              in_valid,
   input  logic [SIMD*mvu_pkg::TSRCI-1:0]    in_act,
   input  logic [PE*SIMD*mvu_pkg::TW-1:0]    in_wgt,
   output logic [PE*SIMD*mvu_pkg::TW-1:0]    wgt_q,
   mvu_beat_if.ctrl                          beat
);

   // Counter needs at least one bit, even for SF of 1.
   localparam int CNT_W = (SF > 1) ? $clog2(SF) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SF - 1);

   // Position of the next beat within the fold.
   logic [CNT_W-1:0] cnt;

   // Fold counter, advances only on valid beats.
   // Gaps leave it untouched.
   always_ff @(posedge clk) begin
      if (rst) begin
         cnt <= '0;
      end else if (in_valid) begin
         if (cnt == CNT_LAST) begin
            cnt <= '0;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // Beat controls, cleared on reset.
   always_ff @(posedge clk) begin
      if (rst) begin
         beat.en    <= 1'b0;
         beat.first <= 1'b0;
         beat.last  <= 1'b0;
      end else begin
         beat.en    <= in_valid;
         beat.first <= in_valid && (cnt == '0);
         beat.last  <= in_valid && (cnt == CNT_LAST);
      end
   end

   // Beat payload, captured with the controls.
   always_ff @(posedge clk) begin
      if (in_valid) begin
         beat.act <= in_act;
         wgt_q    <= in_wgt;
      end
   end

   // Counter wraps before reaching SF.
   a_cnt_range: assert property (@(posedge clk) disable iff (rst) int'(cnt) < SF);

endmodule

/* rtl/mvu_pe.sv */
// MVU processing element: SIMD-wide signed dot product accumulated over one fold.
`timescale 1ns/10ps

module mvu_pe #(
   parameter int SIMD = 4
) (
   input  logic                            clk,
   input  logic                            rst,
   mvu_beat_if.pe                          beat,
   input  logic [SIMD*mvu_pkg::TW-1:0]     wgt,
   output logic signed [mvu_pkg::TACC-1:0] acc,
   output logic                            acc_last
);
   import mvu_pkg::*;

   // Per-element products.
   logic signed [TPROD-1:0] prod [SIMD];
   // Adder tree result for this beat.
   logic signed [TACC-1:0]  dot;

   // Stage 1 registers.
   logic signed [TACC-1:0]  s1_sum;
   logic                    s1_en;
   logic                    s1_first;
   logic                    s1_last;

   // Signed multiply of each activation/weight pair.
   always_comb begin
      for (int i = 0; i < SIMD; i++) begin
         prod[i] = $signed(beat.act[i*TSRCI +: TSRCI]) * $signed(wgt[i*TW +: TW]);
      end
   end

   // Reduction, sign-extended to the accumulator width.
   always_comb begin
      dot = '0;
      for (int i = 0; i < SIMD; i++) begin
         dot = dot + prod[i];
      end
   end

   // Stage 1 controls follow the beat.
   always_ff @(posedge clk) begin
      if (rst) begin
         s1_en    <= 1'b0;
         s1_first <= 1'b0;
         s1_last  <= 1'b0;
      end else begin
         s1_en    <= beat.en;
         s1_first <= beat.first;
         s1_last  <= beat.last;
      end
   end

   // Stage 1 sum.
   always_ff @(posedge clk) begin
      if (beat.en) begin
         s1_sum <= dot;
      end
   end

   // Stage 2 accumulator.
   // First beat replaces the old fold's total.
   always_ff @(posedge clk) begin
      if (s1_en) begin
         if (s1_first) begin
            acc <= s1_sum;
         end else begin
            acc <= acc + s1_sum;
         end
      end
   end

   // Result strobe, one cycle per fold.
   always_ff @(posedge clk) begin
      if (rst) begin
         acc_last <= 1'b0;
      end else begin
         acc_last <= s1_en && s1_last;
      end
   end

   // Fold marks never appear without a valid beat.
   a_marks_need_en: assert property (@(posedge clk) disable iff (rst)
      (beat.first || beat.last) |-> beat.en);

endmodule

/* rtl/mvu_pe_array.sv */
// MVU PE array: PE copies sharing one activation beat, each with its own weight slice.
`timescale 1ns/10ps

module mvu_pe_array #(
   parameter int SIMD = 4,
   parameter int PE   = 4
) (
   input  logic                              clk,
   input  logic                              rst,
   mvu_beat_if.pe                            beat,
   input  logic [PE*SIMD*mvu_pkg::TW-1:0]    wgt,
   output logic [PE*mvu_pkg::TACC-1:0]       acc,
   output logic                              acc_last
);
   import mvu_pkg::*;

   // Result strobes of every copy.
   logic [PE-1:0] pe_last;

   // One PE per output element.
   // PE p reads weights at p*SIMD*TW.
   for (genvar p = 0; p < PE; p++) begin : g_pe
      mvu_pe #(
         .SIMD (SIMD)
      ) u_pe (
         .clk      (clk),
         .rst      (rst),
         .beat     (beat),
         .wgt      (wgt[p*SIMD*TW +: SIMD*TW]),
         .acc      (acc[p*TACC +: TACC]),
         .acc_last (pe_last[p])
      );
   end

   // All copies run in lockstep, so PE 0 speaks for the array.
   assign acc_last = pe_last[0];

endmodule

/* rtl/mvu_out_sat.sv */
// MVU output stage: clamps each PE sum to the output width and strobes the vector out.
`timescale 1ns/10ps

module mvu_out_sat #(
   parameter int PE = 4
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [PE*mvu_pkg::TACC-1:0]    acc,
   input  logic                           acc_last,
   output logic [PE*mvu_pkg::TDSTI-1:0]   out,
   output logic                           out_valid
);
   import mvu_pkg::*;

   // Clamp one signed sum into TDSTI bits.
   function automatic logic [TDSTI-1:0] sat(input logic signed [TACC-1:0] v);
      if (v > ACC_MAX) begin
         return TDSTI'(ACC_MAX);
      end
      if (v < ACC_MIN) begin
         return TDSTI'(ACC_MIN);
      end
      return v[TDSTI-1:0];
   endfunction

   // Output vector, PE 0 in the low bits.
   // Holds until the next fold completes.
   always_ff @(posedge clk) begin
      if (acc_last) begin
         for (int p = 0; p < PE; p++) begin
            out[p*TDSTI +: TDSTI] <= sat(acc[p*TACC +: TACC]);
         end
      end
   end

   // One strobe per result.
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= acc_last;
      end
   end

   // Strobe is a single-cycle pulse.
   a_one_pulse: assert property (@(posedge clk) disable iff (rst)
      out_valid |=> !out_valid);

endmodule

/* rtl/mvu_top.sv */
// MVU top: streaming matrix-vector multiply with fold control, PE array and saturation.
`timescale 1ns/10ps

module mvu_top #(
   parameter int SIMD = 4,
   parameter int PE   = 4,
   parameter int SF   = 8
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              in_valid,
   input  logic [SIMD*mvu_pkg::TSRCI-1:0]    in_act,
   input  logic [PE*SIMD*mvu_pkg::TW-1:0]    in_wgt,
   output logic                              out_valid,
   output logic [PE*mvu_pkg::TDSTI-1:0]      out
);
   import mvu_pkg::*;

   // Weights aligned with the registered beat.
   logic [PE*SIMD*TW-1:0] wgt_q;
   // Accumulated PE sums and their strobe.
   logic [PE*TACC-1:0]    acc;
   logic                  acc_last;

   // Decoded beat.
   mvu_beat_if #(
      .SIMD (SIMD)
   ) beat ();

   // Fold counting, one cycle.
   mvu_fold_ctrl #(
      .SIMD (SIMD),
      .PE   (PE),
      .SF   (SF)
   ) u_fold_ctrl (
      .clk      (clk),
      .rst      (rst),
      .in_valid (in_valid),
      .in_act   (in_act),
      .in_wgt   (in_wgt),
      .wgt_q    (wgt_q),
      .beat     (beat.ctrl)
   );

   // Dot products and accumulation, two cycles.
   mvu_pe_array #(
      .SIMD (SIMD),
      .PE   (PE)
   ) u_pe_array (
      .clk      (clk),
      .rst      (rst),
      .beat     (beat.pe),
      .wgt      (wgt_q),
      .acc      (acc),
      .acc_last (acc_last)
   );

   // Saturation and output strobe, one cycle.
   mvu_out_sat #(
      .PE (PE)
   ) u_out_sat (
      .clk       (clk),
      .rst       (rst),
      .acc       (acc),
      .acc_last  (acc_last),
      .out       (out),
      .out_valid (out_valid)
   );

endmodule

/* sim/mvu_tb_ref.svh */
// MVU reference model: expected output vector of one fold, summed and clamped per PE.
`ifndef MVU_TB_REF_SVH
`define MVU_TB_REF_SVH

// One fold in, one clamped vector out.
// Beat b of the fold sits at b times the beat width.
function automatic logic [PE*TDSTI-1:0] ref_fold(
   input logic [SF*SIMD*TSRCI-1:0] acts,
   input logic [SF*PE*SIMD*TW-1:0] wgts
);
   logic [PE*TDSTI-1:0]     res;
   logic signed [TSRCI-1:0] a;
   logic signed [TW-1:0]    w;
   int                      sum;
   int                      hi;
   int                      lo;
   // Output range of a TDSTI-bit signed value.
   hi  = (1 << (TDSTI - 1)) - 1;
   lo  = -(1 << (TDSTI - 1));
   res = '0;
   for (int p = 0; p < PE; p++) begin
      sum = 0;
      for (int b = 0; b < SF; b++) begin
         for (int i = 0; i < SIMD; i++) begin
            a   = acts[(b*SIMD + i)*TSRCI +: TSRCI];
            w   = wgts[((b*PE + p)*SIMD + i)*TW +: TW];
            sum = sum + int'(a) * int'(w);
         end
      end
      // Saturate.
      if (sum > hi) begin
         sum = hi;
      end else if (sum < lo) begin
         sum = lo;
      end
      res[p*TDSTI +: TDSTI] = TDSTI'(sum);
   end
   return res;
endfunction

`endif

/* sim/mvu_tb.sv */
// MVU testbench: random and directed folds checked against a reference model.
`timescale 1ns/10ps

module mvu_tb;
   import mvu_pkg::*;

   localparam int SIMD       = 4;
   localparam int PE         = 4;
   localparam int SF         = 8;
   localparam int AW         = SIMD * TSRCI;
   localparam int WW         = PE * SIMD * TW;
   localparam int LATENCY    = 4;
   localparam int RST_CYCLES = 5;
   localparam int MAX_GAP    = 3;
   // Folds sent over all tests, plus one partial fold.
   localparam int N_FOLDS    = 13;
   localparam int N_BEATS    = N_FOLDS * SF + SF - 1;
   // Random gaps, drain waits and both resets.
   localparam int N_GAPS     = 4 * SF * MAX_GAP + 6 * 10 + 2 * RST_CYCLES;
   localparam int TIMEOUT    = N_BEATS + N_GAPS + 50;
   localparam logic [TSRCI-1:0] ACT_MIN_E = 1 << (TSRCI - 1);
   localparam logic [TSRCI-1:0] ACT_MAX_E = ACT_MIN_E - 1;
   localparam logic [TW-1:0]    WGT_MIN_E = 1 << (TW - 1);

   logic              clk;
   logic              rst;
   logic              in_valid;
   logic [AW-1:0]     in_act;
   logic [WW-1:0]     in_wgt;
   logic              out_valid;
   logic [PE*TDSTI-1:0] out;

   int seed = 32'h4932;
   int cyc = 0;
   int errors = 0;
   int err_mark = 0;
   int pass_count = 0;
   int fail_count = 0;

   // Expected vectors and the cycle of each fold's last beat.
   logic [PE*TDSTI-1:0] exp_q [$];
   int                  last_q [$];

   // Fold being collected by the monitor.
   logic [SF*AW-1:0] fold_act;
   logic [SF*WW-1:0] fold_wgt;
   int               fold_pos = 0;

   `include "mvu_tb_ref.svh"

   mvu_top #(
      .SIMD (SIMD),
      .PE   (PE),
      .SF   (SF)
   ) UUT (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_act    (in_act),
      .in_wgt    (in_wgt),
      .out_valid (out_valid),
      .out       (out)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Cycle count and watchdog.
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT) begin
         $display("Results did not arrive within %0d cycles", TIMEOUT);
         $display("Test failed");
         $finish;
      end
   end

   // Monitor. Collects sampled beats and predicts each fold's result.
   always @(posedge clk) begin
      if (rst) begin
         fold_pos = 0;
      end else if (in_valid) begin
         fold_act[fold_pos*AW +: AW] = in_act;
         fold_wgt[fold_pos*WW +: WW] = in_wgt;
         if (fold_pos == SF - 1) begin
            exp_q.push_back(ref_fold(fold_act, fold_wgt));
            last_q.push_back(cyc);
            fold_pos = 0;
         end else begin
            fold_pos = fold_pos + 1;
         end
      end
   end

   // Compare each result strobe with the oldest prediction.
   always @(posedge clk) begin
      logic [PE*TDSTI-1:0] exp_v;
      int                  t_last;
      if (!rst && out_valid) begin
         if (exp_q.size() == 0) begin
            $display("Unexpected out_valid at %0t with no fold pending", $time);
            errors++;
         end else begin
            exp_v  = exp_q.pop_front();
            t_last = last_q.pop_front();
            for (int p = 0; p < PE; p++) begin
               if (out[p*TDSTI +: TDSTI] !== exp_v[p*TDSTI +: TDSTI]) begin
                  $display("mismatch at %0t: PE %0d got %0d expected %0d", $time, p,
                           $signed(out[p*TDSTI +: TDSTI]), $signed(exp_v[p*TDSTI +: TDSTI]));
                  errors++;
               end
            end
            if (cyc - t_last != LATENCY) begin
               $display("mismatch at %0t: latency %0d cycles, expected %0d", $time,
                        cyc - t_last, LATENCY);
               errors++;
            end
         end
      end
   end

   function automatic logic [AW-1:0] rand_act();
      return AW'($random(seed));
   endfunction

   // Wide words built from 32-bit chunks.
   function automatic logic [WW-1:0] rand_wgt();
      logic [WW+31:0] bits;
      bits = '0;
      for (int k = 0; k < (WW + 31) / 32; k++) begin
         bits = {bits[WW-1:0], 32'($random(seed))};
      end
      return bits[WW-1:0];
   endfunction

   task automatic send_beat(input logic [AW-1:0] a, input logic [WW-1:0] w);
      @(posedge clk);
      in_valid <= 1'b1;
      in_act   <= a;
      in_wgt   <= w;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         in_valid <= 1'b0;
      end
   endtask

   // Random fold, optional gap after each beat.
   task automatic send_fold(input int max_gap);
      int gap;
      for (int b = 0; b < SF; b++) begin
         send_beat(rand_act(), rand_wgt());
         if (max_gap > 0) begin
            gap = int'($unsigned($random(seed)) % (max_gap + 1));
            idle(gap);
         end
      end
   endtask

   // Let the monitor log the last beat, then wait for outstanding results.
   // A few more cycles catch stray strobes.
   task automatic drain();
      @(posedge clk);
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);
   endtask

   task automatic finish_test(input string name);
      if (errors == err_mark) begin
         pass_count++;
         $display("%s: ok", name);
      end else begin
         fail_count++;
         $display("%s: FAILED with %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   initial begin
      logic [AW-1:0] act_v;
      int            elem;
      int            act_sum;
      in_valid = 1'b0;
      in_act   = '0;
      in_wgt   = '0;
      rst      = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;

      // Unit weights, so each PE returns the activation sum.
      act_sum = 0;
      act_v   = '0;
      for (int b = 0; b < SF; b++) begin
         for (int i = 0; i < SIMD; i++) begin
            elem = ((b * SIMD + i) % 15) - 7;
            act_v[i*TSRCI +: TSRCI] = TSRCI'(elem);
            act_sum += elem;
         end
         send_beat(act_v, {(PE*SIMD){TW'(1)}});
      end
      idle(1);
      drain();
      for (int p = 0; p < PE; p++) begin
         if ($signed(out[p*TDSTI +: TDSTI]) != act_sum) begin
            $display("mismatch at %0t: PE %0d got %0d, activation sum %0d", $time, p,
                     $signed(out[p*TDSTI +: TDSTI]), act_sum);
            errors++;
         end
      end
      finish_test("test 1 directed unit weights");

      // Folds back to back.
      repeat (4) send_fold(0);
      idle(1);
      drain();
      finish_test("test 2 back-to-back folds");

      repeat (4) send_fold(MAX_GAP);
      idle(1);
      drain();
      finish_test("test 3 folds with gaps");

      // Peak positive, then peak negative sums.
      // Clamps only once SF*SIMD products exceed the output range.
      repeat (SF) send_beat({SIMD{ACT_MIN_E}}, {(PE*SIMD){WGT_MIN_E}});
      repeat (SF) send_beat({SIMD{ACT_MAX_E}}, {(PE*SIMD){WGT_MIN_E}});
      idle(1);
      drain();
      finish_test("test 4 extreme values");

      // Latency is checked on every result above.
      send_fold(0);
      idle(1);
      drain();
      finish_test("test 5 latency and single strobe");

      // Partial fold dropped by reset.
      repeat (SF - 1) send_beat(rand_act(), rand_wgt());
      idle(1);
      rst <= 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      send_fold(0);
      idle(1);
      drain();
      finish_test("test 6 reset mid-fold");

      $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
               pass_count, fail_count, errors);
      if (fail_count == 0 && errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+sim
rtl/mvu_pkg.sv
rtl/mvu_beat_if.sv
rtl/mvu_fold_ctrl.sv
rtl/mvu_pe.sv
rtl/mvu_pe_array.sv
rtl/mvu_out_sat.sv
rtl/mvu_top.sv
sim/mvu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mvu_tb \
   -f sim.f -o mvu_sim

./obj_dir/mvu_sim | tee sim.log

if grep -q "Test failed" sim.log; then
   exit 1
fi
exit 0
